// ==== sim.f ====
hdl/fpu_nc_pkg.sv
hdl/fpu_nc_decode.sv
hdl/fpu_sgnj_lane.sv
hdl/fpu_cmp_lane.sv
hdl/fpu_result_merge.sv
hdl/fpu_nc_top.sv
testbench/tb_fpu_nc.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fpu_nc
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/fpu_nc_testdata.txt ====
# columns: test op rs1 rs2 tag result fflags, all hex (nv is fflags bit 4)
# op above 8 is illegal, its result and fflags columns are not used
1 0 ffffffff3f800000 ffffffffbf800000 00101 ffffffffbf800000 00
1 9 ffffffff3f800000 ffffffff3f800000 00102 0000000000000000 00
1 f ffffffff40000000 ffffffff40000000 00103 0000000000000000 00
1 1 ffffffff40000000 ffffffff40000000 00105 ffffffffc0000000 00
2 0 ffffffff40000000 ffffffff80000000 00201 ffffffffc0000000 00
2 1 ffffffff3f800000 ffffffffbf800000 00205 ffffffff3f800000 00
2 2 ffffffffbf800000 ffffffffbf800000 00207 ffffffff3f800000 00
2 2 ffffffffbf800000 ffffffff3f800000 00209 ffffffffbf800000 00
2 1 ffffffff7fc00000 ffffffff00000000 0020b ffffffffffc00000 00
3 5 ffffffff3f800000 ffffffff3f800000 00300 0000000000000001 00
3 5 ffffffff80000000 ffffffff00000000 00302 0000000000000001 00
3 5 ffffffff7fc00000 ffffffff3f800000 00304 0000000000000000 00
3 5 ffffffff7f800001 ffffffff3f800000 00306 0000000000000000 10
3 6 ffffffff3f800000 ffffffff40000000 00308 0000000000000001 00
3 6 ffffffff80000000 ffffffff00000000 0030a 0000000000000000 00
3 6 ffffffffc0000000 ffffffffbf800000 0030c 0000000000000001 00
3 6 ffffffff7fc00000 ffffffff3f800000 0030e 0000000000000000 10
3 7 ffffffff80000000 ffffffff00000000 00310 0000000000000001 00
3 7 ffffffff40000000 ffffffff3f800000 00312 0000000000000000 00
3 7 ffffffff3f800000 ffffffff7fc00000 00314 0000000000000000 10
3 7 ffffffffff800000 ffffffffc0000000 00316 0000000000000001 00
4 3 ffffffff80000000 ffffffff00000000 00401 ffffffff80000000 00
4 4 ffffffff80000000 ffffffff00000000 00403 ffffffff00000000 00
4 3 ffffffff00000000 ffffffff80000000 00405 ffffffff80000000 00
4 4 ffffffff7fc00000 ffffffff3f800000 00407 ffffffff3f800000 00
4 3 ffffffff40000000 ffffffff7f800001 00409 ffffffff40000000 10
4 4 ffffffff7fc00000 ffffffff7f800001 0040b ffffffff7fc00000 10
4 3 ffffffffffc00001 ffffffff7fc00000 0040d ffffffff7fc00000 00
4 3 ffffffffbf800000 ffffffffc0000000 0040f ffffffffc0000000 00
4 8 ffffffffff800000 ffffffff00000000 00420 0000000000000001 00
4 8 ffffffffbf800000 ffffffff00000000 00422 0000000000000002 00
4 8 ffffffff80000001 ffffffff00000000 00424 0000000000000004 00
4 8 ffffffff80000000 ffffffff00000000 00426 0000000000000008 00
4 8 ffffffff00000000 ffffffff00000000 00428 0000000000000010 00
4 8 ffffffff00000001 ffffffff00000000 0042a 0000000000000020 00
4 8 ffffffff3f800000 ffffffff00000000 0042c 0000000000000040 00
4 8 ffffffff7f800000 ffffffff00000000 0042e 0000000000000080 00
4 8 ffffffff7f800001 ffffffff00000000 00430 0000000000000100 00
4 8 ffffffff7fc00000 ffffffff00000000 00432 0000000000000200 00
5 8 000000003f800000 ffffffff00000000 00500 0000000000000200 00
5 8 7fffffff3f800000 ffffffff00000000 00502 0000000000000200 00
5 0 0000000040000000 ffffffffbf800000 00505 ffffffffffc00000 00
5 0 ffffffff3f800000 00000000bf800000 00507 ffffffff3f800000 00
5 5 ffffffff3f800000 ffffffef3f800000 00508 0000000000000000 00
5 6 123456783f800000 ffffffff3f800000 0050a 0000000000000000 10
5 4 0000000040000000 00000000c0000000 0050d ffffffff7fc00000 00
6 0 ffffffff3f800000 ffffffffbf800000 3f001 ffffffffbf800000 00
6 5 ffffffff3f800000 ffffffff3f800000 3f002 0000000000000001 00
6 1 ffffffff40000000 ffffffff40000000 3f003 ffffffffc0000000 00
6 4 ffffffff3f800000 ffffffffbf800000 3f004 ffffffff3f800000 00
6 2 ffffffffc0000000 ffffffffbf800000 3f005 ffffffff40000000 00
6 8 ffffffff3f800000 ffffffff00000000 3f006 0000000000000040 00

// ==== testbench/tb_fpu_nc.sv ====
`timescale 1ns/1ps

module tb_fpu_nc;

  import fpu_nc_pkg::*;

  localparam int    PIPE_STAGES  = 2;    // same as the DUT default
  localparam int    CLK_PERIOD   = 100;  // ns
  localparam int    RESET_CYCLES = 16;
  localparam string DATA_FILE    = "testbench/fpu_nc_testdata.txt";

  typedef struct packed {
    logic [7:0] test;
    logic [3:0] op;
    flen_t      rs1;
    flen_t      rs2;
    fpu_tag_t   tag;
    flen_t      result;
    fflags_t    fflags;
  } vector_t;

  typedef struct packed {
    logic [7:0]  test;
    flen_t       result;
    fflags_t     fflags;
    fpu_tag_t    tag;
    logic [31:0] due;  // checker cycle where o_valid must be seen
  } expect_t;

  logic     i_clk;
  logic     i_reset_n;
  logic     i_valid;
  fpu_op_e  i_op;
  fpu_tag_t i_tag;
  flen_t    i_rs1;
  flen_t    i_rs2;
  logic     o_valid;
  flen_t    o_result;
  fflags_t  o_fflags;
  fpu_tag_t o_tag;

  vector_t     vecs [$];
  expect_t     exp_q [$];  // issued ops still waiting for a result
  int          cycle        = 0;
  int          err_count    = 0;
  int          group_base   = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  bit          loaded       = 1'b0;
  logic [31:0] lfsr_state   = 32'h5c567dce;

  fpu_nc_top uut (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_valid),
    .i_op      (i_op),
    .i_tag     (i_tag),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .o_valid   (o_valid),
    .o_result  (o_result),
    .o_fflags  (o_fflags),
    .o_tag     (o_tag)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_gap(output int gap);
    gap = 0;
    repeat (2) begin
      lfsr_state = lfsr_next(lfsr_state);
      gap = (gap << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic load_vectors();
    int         fd;
    int         n;
    string      line;
    logic [7:0] t;
    logic [3:0] op;
    flen_t      rs1;
    flen_t      rs2;
    flen_t      res;
    logic [17:0] tag;
    logic [4:0] ff;
    vector_t    v;
    fd = $fopen(DATA_FILE, "r");
    assert (fd != 0) else begin
      $display("could not open the vector file %s", DATA_FILE);
      err_count++;
    end
    if (fd != 0) begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        n = $sscanf(line, "%h %h %h %h %h %h %h", t, op, rs1, rs2, tag, res, ff);
        if (n == 7) begin  // comment and blank lines give fewer fields
          v.test   = t;
          v.op     = op;
          v.rs1    = rs1;
          v.rs2    = rs2;
          v.tag    = tag;
          v.result = res;
          v.fflags = ff;
          vecs.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic issue(input vector_t v);
    expect_t e;
    @(negedge i_clk);
    i_valid = 1'b1;
    i_op    = fpu_op_e'(v.op);
    i_tag   = v.tag;
    i_rs1   = v.rs1;
    i_rs2   = v.rs2;
    if (v.op <= 4'h8) begin  // codes past FCLASS are illegal, nothing comes back
      e.test   = v.test;
      e.result = v.result;
      e.fflags = v.fflags;
      e.tag    = v.tag;
      e.due    = cycle + PIPE_STAGES + 2;
      exp_q.push_back(e);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge i_clk);
      i_valid = 1'b0;
    end
  endtask

  task automatic finish_group(input logic [7:0] test);
    int group_errs;
    idle(1);
    while (exp_q.size() != 0) @(negedge i_clk);
    idle(PIPE_STAGES + 2);  // room for a stray result to show up
    group_errs = err_count - group_base;
    group_base = err_count;
    if (group_errs == 0) begin
      tests_passed++;
      $display("test %0d: ok", test);
    end else begin
      tests_failed++;
      $display("test %0d: %0d error(s)", test, group_errs);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    assert (act_v === exp_v) else begin
      $display("ERROR: time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
      err_count++;
    end
  endtask

  // ----------------------------------------
  // output checker
  // ----------------------------------------
  always @(posedge i_clk) begin
    expect_t e;
    cycle = cycle + 1;
    if (!i_reset_n) begin
      assert (!o_valid) else begin
        $display("o_valid went high during reset at time %0t", $time);
        err_count++;
      end
    end else if (o_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("a result came out at time %0t with no operation in flight", $time);
        err_count++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (cycle == int'(e.due)) else begin
          $display("test %0d: result came out early at time %0t", e.test, $time);
          err_count++;
        end
        check_value("o_result", e.result, o_result);
        check_value("o_fflags", {59'd0, e.fflags}, {59'd0, o_fflags});
        check_value("o_tag", {46'd0, e.tag}, {46'd0, o_tag});
      end
    end else if (exp_q.size() != 0) begin
      assert (cycle < int'(exp_q[0].due)) else begin
        $display("test %0d: no result %0d cycles after issue, time %0t",
                 exp_q[0].test, PIPE_STAGES + 1, $time);
        err_count++;
        void'(exp_q.pop_front());
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    int gap;
    i_reset_n = 1'b0;
    i_valid   = 1'b0;
    i_op      = FSGNJ;
    i_tag     = '0;
    i_rs1     = '0;
    i_rs2     = '0;
    load_vectors();
    assert (vecs.size() != 0) else begin
      $display("the vector file holds no operations");
      err_count++;
    end
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_reset_n = 1'b1;
    idle(2);  // o_valid must stay low here
    for (int k = 0; k < vecs.size(); k++) begin
      issue(vecs[k]);
      if (vecs[k].test != 8'd6) begin  // test 6 runs back to back
        pick_gap(gap);
        idle(gap);
      end
      if (k == vecs.size() - 1 || vecs[k + 1].test != vecs[k].test) begin
        finish_group(vecs[k].test);
      end
    end
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    int limit;
    wait (loaded);
    limit = RESET_CYCLES + vecs.size() * (3 + PIPE_STAGES + 2) + 20;
    repeat (limit) @(posedge i_clk);
    $display("timeout: the run did not finish within %0d clock periods", limit);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== hdl/fpu_nc_top.sv ====
`timescale 1ns/1ps

module fpu_nc_top #(
  parameter int PIPE_STAGES = 2  // register depth of each lane
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic                 i_valid,
  input  fpu_nc_pkg::fpu_op_e  i_op,
  input  fpu_nc_pkg::fpu_tag_t i_tag,
  input  fpu_nc_pkg::flen_t    i_rs1,
  input  fpu_nc_pkg::flen_t    i_rs2,

  output logic                 o_valid,
  output fpu_nc_pkg::flen_t    o_result,
  output fpu_nc_pkg::fflags_t  o_fflags,
  output fpu_nc_pkg::fpu_tag_t o_tag
);

  import fpu_nc_pkg::*;

  lane_req_t w_sgnj_req;
  lane_req_t w_cmp_req;
  lane_rsp_t w_sgnj_rsp;
  lane_rsp_t w_cmp_rsp;

  fpu_nc_decode u_decode (
    .i_valid    (i_valid),
    .i_op       (i_op),
    .i_tag      (i_tag),
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .o_sgnj_req (w_sgnj_req),
    .o_cmp_req  (w_cmp_req)
  );

  // ----------------------------------------
  // lanes, equal depth
  // ----------------------------------------
  fpu_sgnj_lane #(.PIPE_STAGES(PIPE_STAGES)) u_sgnj_lane (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req     (w_sgnj_req),
    .o_rsp     (w_sgnj_rsp)
  );

  fpu_cmp_lane #(.PIPE_STAGES(PIPE_STAGES)) u_cmp_lane (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req     (w_cmp_req),
    .o_rsp     (w_cmp_rsp)
  );

  fpu_result_merge u_merge (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_sgnj_rsp (w_sgnj_rsp),
    .i_cmp_rsp  (w_cmp_rsp),
    .o_valid    (o_valid),
    .o_result   (o_result),
    .o_fflags   (o_fflags),
    .o_tag      (o_tag)
  );

endmodule

// ==== hdl/fpu_result_merge.sv ====
`timescale 1ns/1ps

module fpu_result_merge (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  fpu_nc_pkg::lane_rsp_t i_sgnj_rsp,
  input  fpu_nc_pkg::lane_rsp_t i_cmp_rsp,
  output logic                  o_valid,
  output fpu_nc_pkg::flen_t     o_result,
  output fpu_nc_pkg::fflags_t   o_fflags,
  output fpu_nc_pkg::fpu_tag_t  o_tag
);

  // ----------------------------------------
  // output register
  // ----------------------------------------
  // lanes have equal depth so at most one of them is valid in a cycle
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid  <= 1'b0;
      o_result <= '0;
      o_fflags <= '0;
      o_tag    <= '0;
    end else if (i_sgnj_rsp.valid) begin
      o_valid  <= 1'b1;
      o_result <= i_sgnj_rsp.result;
      o_fflags <= i_sgnj_rsp.fflags;
      o_tag    <= i_sgnj_rsp.tag;
    end else if (i_cmp_rsp.valid) begin
      o_valid  <= 1'b1;
      o_result <= i_cmp_rsp.result;
      o_fflags <= i_cmp_rsp.fflags;
      o_tag    <= i_cmp_rsp.tag;
    end else begin
      o_valid  <= 1'b0;  // idle cycle, outputs cleared
      o_result <= '0;
      o_fflags <= '0;
      o_tag    <= '0;
    end
  end

endmodule

// ==== hdl/fpu_cmp_lane.sv ====
`timescale 1ns/1ps

module fpu_cmp_lane #(
  parameter int PIPE_STAGES = 2
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  fpu_nc_pkg::lane_req_t i_req,
  output fpu_nc_pkg::lane_rsp_t o_rsp
);

  import fpu_nc_pkg::*;

  // bit order of the riscv class mask
  //   0 -inf, 1 -normal, 2 -subnormal, 3 -0, 4 +0
  //   5 +subnormal, 6 +normal, 7 +inf, 8 snan, 9 qnan
  function automatic logic [9:0] class_mask(input sp_t x);
    logic exp_max;
    logic exp_zero;
    logic man_zero;
    logic neg;
    exp_max  = &x[30:23];
    exp_zero = ~|x[30:23];
    man_zero = ~|x[22:0];
    neg      = x[31];
    class_mask = '0;
    if (exp_max && !man_zero) begin
      class_mask[9] = x[22];   // quiet bit set
      class_mask[8] = ~x[22];
    end else if (exp_max) begin
      class_mask[neg ? 0 : 7] = 1'b1;
    end else if (exp_zero && man_zero) begin
      class_mask[neg ? 3 : 4] = 1'b1;
    end else if (exp_zero) begin
      class_mask[neg ? 2 : 5] = 1'b1;
    end else begin
      class_mask[neg ? 1 : 6] = 1'b1;
    end
    return class_mask;
  endfunction

  logic [9:0] w_cls_a;
  logic [9:0] w_cls_b;
  logic       w_nan_a;
  logic       w_nan_b;
  logic       w_any_nan;
  logic       w_any_snan;
  logic       w_both_zero;
  logic       w_lt_mm;     // a below b, -0 under +0
  logic       w_lt;
  logic       w_eq;
  sp_t        w_min;
  sp_t        w_max;
  lane_rsp_t  w_rsp;
  lane_rsp_t  r_pipe [PIPE_STAGES];

  // ----------------------------------------
  // operand classes
  // ----------------------------------------
  assign w_cls_a     = class_mask(i_req.a);
  assign w_cls_b     = class_mask(i_req.b);
  assign w_nan_a     = w_cls_a[8] | w_cls_a[9];
  assign w_nan_b     = w_cls_b[8] | w_cls_b[9];
  assign w_any_nan   = w_nan_a | w_nan_b;
  assign w_any_snan  = w_cls_a[8] | w_cls_b[8];
  assign w_both_zero = (w_cls_a[3] | w_cls_a[4]) & (w_cls_b[3] | w_cls_b[4]);

  // ----------------------------------------
  // ordering, valid for non-nan operands
  // ----------------------------------------
  assign w_lt_mm = (i_req.a[31] != i_req.b[31]) ? i_req.a[31] :
                   i_req.a[31] ? (i_req.a[30:0] > i_req.b[30:0]) :
                                 (i_req.a[30:0] < i_req.b[30:0]);
  assign w_lt = w_lt_mm & ~w_both_zero;              // ieee view, -0 == +0
  assign w_eq = (i_req.a == i_req.b) | w_both_zero;

  always_comb begin
    if (w_nan_a && w_nan_b) begin
      w_min = CANON_NAN_SP;
      w_max = CANON_NAN_SP;
    end else if (w_nan_a) begin
      w_min = i_req.b;
      w_max = i_req.b;
    end else if (w_nan_b) begin
      w_min = i_req.a;
      w_max = i_req.a;
    end else begin
      w_min = w_lt_mm ? i_req.a : i_req.b;
      w_max = w_lt_mm ? i_req.b : i_req.a;
    end
  end

  // ----------------------------------------
  // result select
  // ----------------------------------------
  always_comb begin
    w_rsp.valid  = i_req.valid;
    w_rsp.tag    = i_req.tag;
    w_rsp.fflags = '0;
    case (i_req.op)
      FMIN: begin
        w_rsp.result    = {{(FLEN_W-SP_W){1'b1}}, w_min};
        w_rsp.fflags.nv = w_any_snan;
      end
      FMAX: begin
        w_rsp.result    = {{(FLEN_W-SP_W){1'b1}}, w_max};
        w_rsp.fflags.nv = w_any_snan;
      end
      FEQ: begin
        w_rsp.result    = {{(FLEN_W-1){1'b0}}, ~w_any_nan & w_eq};
        w_rsp.fflags.nv = w_any_snan;  // quiet compare
      end
      FLT: begin
        w_rsp.result    = {{(FLEN_W-1){1'b0}}, ~w_any_nan & w_lt};
        w_rsp.fflags.nv = w_any_nan;   // signaling compare
      end
      FLE: begin
        w_rsp.result    = {{(FLEN_W-1){1'b0}}, ~w_any_nan & (w_lt | w_eq)};
        w_rsp.fflags.nv = w_any_nan;
      end
      default: begin  // FCLASS
        w_rsp.result = {{(FLEN_W-10){1'b0}}, w_cls_a};
      end
    endcase
  end

  // ----------------------------------------
  // pipeline
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < PIPE_STAGES; i++) begin
        r_pipe[i] <= '0;
      end
    end else begin
      r_pipe[0] <= w_rsp;
      for (int i = 1; i < PIPE_STAGES; i++) begin
        r_pipe[i] <= r_pipe[i-1];
      end
    end
  end

  assign o_rsp = r_pipe[PIPE_STAGES-1];

endmodule

// ==== hdl/fpu_sgnj_lane.sv ====
`timescale 1ns/1ps

module fpu_sgnj_lane #(
  parameter int PIPE_STAGES = 2
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  fpu_nc_pkg::lane_req_t i_req,
  output fpu_nc_pkg::lane_rsp_t o_rsp
);

  import fpu_nc_pkg::*;

  logic      w_sign;
  lane_rsp_t w_rsp;
  lane_rsp_t r_pipe [PIPE_STAGES];

  // ----------------------------------------
  // sign selection
  // ----------------------------------------
  always_comb begin
    case (i_req.op)
      FSGNJ:   w_sign = i_req.b[SP_W-1];
      FSGNJN:  w_sign = ~i_req.b[SP_W-1];
      FSGNJX:  w_sign = i_req.a[SP_W-1] ^ i_req.b[SP_W-1];
      default: w_sign = i_req.a[SP_W-1];  // keep a unchanged
    endcase
  end

  assign w_rsp.valid  = i_req.valid;
  assign w_rsp.result = {{(FLEN_W-SP_W){1'b1}}, w_sign, i_req.a[SP_W-2:0]};  // boxed
  assign w_rsp.fflags = '0;  // sign ops never raise flags
  assign w_rsp.tag    = i_req.tag;

  // ----------------------------------------
  // pipeline
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < PIPE_STAGES; i++) begin
        r_pipe[i] <= '0;
      end
    end else begin
      r_pipe[0] <= w_rsp;
      for (int i = 1; i < PIPE_STAGES; i++) begin
        r_pipe[i] <= r_pipe[i-1];
      end
    end
  end

  assign o_rsp = r_pipe[PIPE_STAGES-1];

endmodule

// ==== hdl/fpu_nc_decode.sv ====
`timescale 1ns/1ps

module fpu_nc_decode (
  input  logic                  i_valid,
  input  fpu_nc_pkg::fpu_op_e   i_op,
  input  fpu_nc_pkg::fpu_tag_t  i_tag,
  input  fpu_nc_pkg::flen_t     i_rs1,
  input  fpu_nc_pkg::flen_t     i_rs2,
  output fpu_nc_pkg::lane_req_t o_sgnj_req,
  output fpu_nc_pkg::lane_req_t o_cmp_req
);

  import fpu_nc_pkg::*;

  logic w_to_sgnj;
  logic w_to_cmp;
  sp_t  w_a;
  sp_t  w_b;

  // a broken box reads as the canonical nan
  assign w_a = (&i_rs1[FLEN_W-1:SP_W]) ? i_rs1[SP_W-1:0] : CANON_NAN_SP;
  assign w_b = (&i_rs2[FLEN_W-1:SP_W]) ? i_rs2[SP_W-1:0] : CANON_NAN_SP;

  always_comb begin
    case (i_op)
      FSGNJ, FSGNJN, FSGNJX: begin
        w_to_sgnj = 1'b1;
        w_to_cmp  = 1'b0;
      end
      FMIN, FMAX, FEQ, FLT, FLE, FCLASS: begin
        w_to_sgnj = 1'b0;
        w_to_cmp  = 1'b1;
      end
      default: begin  // illegal code, dropped here
        w_to_sgnj = 1'b0;
        w_to_cmp  = 1'b0;
      end
    endcase
  end

  // both lanes see the same payload, only valid differs
  assign o_sgnj_req.valid = i_valid & w_to_sgnj;
  assign o_sgnj_req.op    = i_op;
  assign o_sgnj_req.a     = w_a;
  assign o_sgnj_req.b     = w_b;
  assign o_sgnj_req.tag   = i_tag;

  assign o_cmp_req.valid  = i_valid & w_to_cmp;
  assign o_cmp_req.op     = i_op;
  assign o_cmp_req.a      = w_a;
  assign o_cmp_req.b      = w_b;
  assign o_cmp_req.tag    = i_tag;

endmodule

// ==== hdl/fpu_nc_pkg.sv ====
package fpu_nc_pkg;

  // ----------------------------------------
  // widths and constants
  // ----------------------------------------
  localparam int FLEN_W = 64;  // register file width
  localparam int SP_W   = 32;  // single precision

  localparam logic [SP_W-1:0] CANON_NAN_SP = 32'h7fc0_0000;  // positive quiet nan

  typedef logic [FLEN_W-1:0] flen_t;
  typedef logic [SP_W-1:0]   sp_t;

  // ----------------------------------------
  // opcodes and register kinds
  // ----------------------------------------
  // codes 9 to 15 are illegal and never issue to a lane
  typedef enum logic [3:0] {
    FSGNJ  = 4'h0,
    FSGNJN = 4'h1,
    FSGNJX = 4'h2,
    FMIN   = 4'h3,
    FMAX   = 4'h4,
    FEQ    = 4'h5,
    FLT    = 4'h6,
    FLE    = 4'h7,
    FCLASS = 4'h8
  } fpu_op_e;

  typedef enum logic {
    GPR = 1'b0,  // integer destination
    FPR = 1'b1   // fp destination
  } reg_kind_e;

  // ----------------------------------------
  // bundles
  // ----------------------------------------
  typedef struct packed {
    logic nv;  // invalid operation
    logic dz;  // divide by zero
    logic of;  // overflow
    logic uf;  // underflow
    logic nx;  // inexact
  } fflags_t;

  // renaming info, echoed with the result
  typedef struct packed {
    logic [5:0] cmt_id;
    logic [3:0] grp_id;
    logic [6:0] rnid;
    reg_kind_e  reg_kind;
  } fpu_tag_t;

  typedef struct packed {
    logic     valid;
    fpu_op_e  op;
    sp_t      a;  // unboxed rs1
    sp_t      b;  // unboxed rs2
    fpu_tag_t tag;
  } lane_req_t;

  typedef struct packed {
    logic     valid;
    flen_t    result;
    fflags_t  fflags;
    fpu_tag_t tag;
  } lane_rsp_t;

endpackage
